/* verilog/fpi_isa_pkg.sv */
package fpi_isa_pkg;

   // Data and register index widths
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // R-type layout, also covers FLW and FSW fields used here
   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } f_instr_s;

   // Major opcodes
   localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
   localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
   localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

   // funct7 groups for single precision
   localparam logic [6:0] F7_SGNJ    = 7'b0010000;
   localparam logic [6:0] F7_MINMAX  = 7'b0010100;
   localparam logic [6:0] F7_CMP     = 7'b1010000;
   localparam logic [6:0] F7_MV_X_W  = 7'b1110000;
   localparam logic [6:0] F7_MV_W_X  = 7'b1111000;

   // funct3 selectors inside each group
   localparam logic [2:0] F3_SGNJ  = 3'b000;
   localparam logic [2:0] F3_SGNJN = 3'b001;
   localparam logic [2:0] F3_SGNJX = 3'b010;
   localparam logic [2:0] F3_MIN   = 3'b000;
   localparam logic [2:0] F3_MAX   = 3'b001;
   localparam logic [2:0] F3_FEQ   = 3'b010;
   localparam logic [2:0] F3_FLT   = 3'b001;
   localparam logic [2:0] F3_FLE   = 3'b000;
   localparam logic [2:0] F3_MV    = 3'b000;
   // Width field of FLW and FSW
   localparam logic [2:0] F3_WORD  = 3'b010;

endpackage

/* verilog/fpi_pipe_pkg.sv */
package fpi_pipe_pkg;

   // Operation select for the FIU
   typedef enum logic [3:0] {
      NONE,
      SGNJ,
      SGNJN,
      SGNJX,
      MIN,
      MAX,
      EQ,
      LT,
      LE,
      MV_X,
      MV_F
   } fiu_op_e;

   // Control bits produced by the decoder
   typedef struct packed {
      logic    op_reads_rf1;
      logic    op_writes_frf;
      logic    op_writes_rf;
      logic    is_load_op;
      logic    is_store_op;
      fiu_op_e fiu_op;
   } f_decode_s;

   // ID holds the raw word so rs1, rs2 and rd stay available
   typedef struct packed {
      fpi_isa_pkg::f_instr_s f_instruction;
      f_decode_s             f_decode;
   } f_id_s;

   typedef struct packed {
      f_decode_s              f_decode;
      fpi_isa_pkg::reg_addr_t frd_addr;
      fpi_isa_pkg::word_t     frs1_val;
      fpi_isa_pkg::word_t     frs2_val;
   } f_exe_s;

   typedef struct packed {
      logic                   op_writes_frf;
      logic                   is_load_op;
      fpi_isa_pkg::reg_addr_t frd_addr;
      fpi_isa_pkg::word_t     fiu_result;
   } f_mem_s;

   // Shared by WB and WB1
   typedef struct packed {
      logic                   op_writes_frf;
      fpi_isa_pkg::reg_addr_t frd_addr;
      fpi_isa_pkg::word_t     frf_data;
   } f_wb_s;

endpackage

/* verilog/float_decode.sv */
`timescale 1ns/1ps

module float_decode
(
   input  fpi_isa_pkg::f_instr_s   f_instruction_i,
   output fpi_pipe_pkg::f_decode_s f_decode_o
);

   import fpi_isa_pkg::*;
   import fpi_pipe_pkg::*;

   fiu_op_e fiu_op;
   logic    is_load;
   logic    is_store;

   // Pick the FIU operation from opcode, funct7 and funct3
   always_comb
   begin
      fiu_op   = NONE;
      is_load  = 1'b0;
      is_store = 1'b0;
      case (f_instruction_i.opcode)
         OPC_LOAD_FP:
            is_load = (f_instruction_i.funct3 == F3_WORD);
         OPC_STORE_FP:
            is_store = (f_instruction_i.funct3 == F3_WORD);
         OPC_OP_FP:
         begin
            case (f_instruction_i.funct7)
               F7_SGNJ:
               begin
                  case (f_instruction_i.funct3)
                     F3_SGNJ:  fiu_op = SGNJ;
                     F3_SGNJN: fiu_op = SGNJN;
                     F3_SGNJX: fiu_op = SGNJX;
                     default:  fiu_op = NONE;
                  endcase
               end
               F7_MINMAX:
               begin
                  if (f_instruction_i.funct3 == F3_MIN)
                     fiu_op = MIN;
                  else if (f_instruction_i.funct3 == F3_MAX)
                     fiu_op = MAX;
               end
               F7_CMP:
               begin
                  case (f_instruction_i.funct3)
                     F3_FEQ:  fiu_op = EQ;
                     F3_FLT:  fiu_op = LT;
                     F3_FLE:  fiu_op = LE;
                     default: fiu_op = NONE;
                  endcase
               end
               F7_MV_X_W:
                  if (f_instruction_i.funct3 == F3_MV)
                     fiu_op = MV_X;
               F7_MV_W_X:
                  if (f_instruction_i.funct3 == F3_MV)
                     fiu_op = MV_F;
               default:
                  fiu_op = NONE;
            endcase
         end
         default:
            fiu_op = NONE;
      endcase
   end

   // Flags follow from the operation, unknown words end up as NOP
   always_comb
   begin
      f_decode_o.fiu_op        = fiu_op;
      f_decode_o.is_load_op    = is_load;
      f_decode_o.is_store_op   = is_store;
      // Only FMV.W.X sources the integer register file
      f_decode_o.op_reads_rf1  = (fiu_op == MV_F);
      // Compares and FMV.X.W land in an integer register
      f_decode_o.op_writes_rf  = (fiu_op inside {EQ, LT, LE, MV_X});
      f_decode_o.op_writes_frf = is_load
                                 || (fiu_op inside {SGNJ, SGNJN, SGNJX, MIN, MAX, MV_F});
   end

endmodule

/* verilog/fiu.sv */
`timescale 1ns/1ps

module fiu
(
   input  fpi_isa_pkg::word_t    frs1_i,
   input  fpi_isa_pkg::word_t    frs2_i,
   input  fpi_pipe_pkg::fiu_op_e op_i,
   output fpi_isa_pkg::word_t    result_o
);

   import fpi_isa_pkg::*;
   import fpi_pipe_pkg::*;

   // Canonical quiet NaN for single precision
   localparam word_t CANON_NAN = 32'h7FC0_0000;

   logic a_sign;
   logic b_sign;
   logic a_nan;
   logic b_nan;
   logic any_nan;
   logic both_zero;
   logic a_lt_b;
   logic feq;
   logic flt;
   logic fle;
   word_t fmin;
   word_t fmax;

   assign a_sign = frs1_i[XLEN-1];
   assign b_sign = frs2_i[XLEN-1];

   // Exponent all ones with a nonzero fraction
   assign a_nan   = (frs1_i[30:23] == 8'hFF) && (frs1_i[22:0] != '0);
   assign b_nan   = (frs2_i[30:23] == 8'hFF) && (frs2_i[22:0] != '0);
   assign any_nan = a_nan | b_nan;

   // +0 and -0 together
   assign both_zero = (frs1_i[30:0] == '0) && (frs2_i[30:0] == '0);

   // Sign-magnitude order, -0 sits below +0 here
   always_comb
   begin
      if (a_sign != b_sign)
         a_lt_b = a_sign;
      else if (!a_sign)
         a_lt_b = frs1_i[30:0] < frs2_i[30:0];
      else
         a_lt_b = frs1_i[30:0] > frs2_i[30:0];
   end

   // IEEE compares treat the two zeros as equal
   assign feq = !any_nan && ((frs1_i == frs2_i) || both_zero);
   assign flt = !any_nan && a_lt_b && !both_zero;
   assign fle = flt | feq;

   // A single NaN operand yields the other one
   always_comb
   begin
      if (a_nan && b_nan)
      begin
         fmin = CANON_NAN;
         fmax = CANON_NAN;
      end
      else if (a_nan)
      begin
         fmin = frs2_i;
         fmax = frs2_i;
      end
      else if (b_nan)
      begin
         fmin = frs1_i;
         fmax = frs1_i;
      end
      else
      begin
         fmin = a_lt_b ? frs1_i : frs2_i;
         fmax = a_lt_b ? frs2_i : frs1_i;
      end
   end

   // Result select
   always_comb
   begin
      case (op_i)
         SGNJ:        result_o = {b_sign, frs1_i[30:0]};
         SGNJN:       result_o = {~b_sign, frs1_i[30:0]};
         SGNJX:       result_o = {a_sign ^ b_sign, frs1_i[30:0]};
         MIN:         result_o = fmin;
         MAX:         result_o = fmax;
         EQ:          result_o = {{(XLEN-1){1'b0}}, feq};
         LT:          result_o = {{(XLEN-1){1'b0}}, flt};
         LE:          result_o = {{(XLEN-1){1'b0}}, fle};
         // Moves are bit copies of rs1
         MV_X, MV_F:  result_o = frs1_i;
         default:     result_o = '0;
      endcase
   end

endmodule

/* verilog/frf_2r1w.sv */
`timescale 1ns/1ps

module frf_2r1w
#(
   parameter int width_p = 32,
   parameter int els_p   = 32
)
(
   input  logic                     clk,
   input  logic                     w_v_i,
   input  logic [$clog2(els_p)-1:0] w_addr_i,
   input  logic [width_p-1:0]       w_data_i,
   input  logic [$clog2(els_p)-1:0] r0_addr_i,
   output logic [width_p-1:0]       r0_data_o,
   input  logic [$clog2(els_p)-1:0] r1_addr_i,
   output logic [width_p-1:0]       r1_data_o
);

   // Storage array, contents survive reset
   logic [width_p-1:0] regs [els_p];

   always_ff @(posedge clk)
   begin
      if (w_v_i)
         regs[w_addr_i] <= w_data_i;
   end

   // Write-through so a read in the write cycle sees new data
   assign r0_data_o = (w_v_i && (w_addr_i == r0_addr_i)) ? w_data_i : regs[r0_addr_i];
   assign r1_data_o = (w_v_i && (w_addr_i == r1_addr_i)) ? w_data_i : regs[r1_addr_i];

endmodule

/* verilog/fpi.sv */
`timescale 1ns/1ps

module fpi
(
   input  logic                  clk,
   input  logic                  reset,
   input  fpi_isa_pkg::f_instr_s f_instruction_i,
   input  logic                  alu_stall_i,
   input  logic                  alu_flush_i,
   input  fpi_isa_pkg::word_t    rf_rs1_i,
   input  fpi_isa_pkg::word_t    flw_data_i,
   output fpi_isa_pkg::word_t    exe_int_result_o,
   output fpi_isa_pkg::word_t    exe_frs2_o,
   output logic                  exe_store_op_o,
   output logic                  exe_writes_rf_o
);

   import fpi_isa_pkg::*;
   import fpi_pipe_pkg::*;

   // Float register count
   localparam int FRF_ELS = 32;

   // Stage registers
   f_id_s  id;
   f_exe_s exe;
   f_mem_s mem;
   f_wb_s  wb;
   f_wb_s  wb1;

   f_decode_s f_decode;
   word_t     frf_rs1_data;
   word_t     frf_rs2_data;
   word_t     frs1_to_exe;
   word_t     fiu_result;
   word_t     frf_data;
   logic      advance;
   logic      flush_now;
   logic      frf_w_v;

   // Any unstalled edge moves every stage
   assign advance   = ~alu_stall_i;
   // Flush only counts on an edge that advances
   assign flush_now = alu_flush_i & advance;

   // Decode the word as it arrives
   float_decode u_decode
   (
      .f_instruction_i (f_instruction_i),
      .f_decode_o      (f_decode)
   );

   // Fetch input to ID
   always_ff @(posedge clk)
   begin
      if (reset || flush_now)
         id <= '0;
      else if (advance)
         id <= '{f_instruction: f_instruction_i, f_decode: f_decode};
   end

   // WB1 writes the FRF, held off while stalled
   assign frf_w_v = wb1.op_writes_frf & advance;

   frf_2r1w
   #(
      .width_p (XLEN),
      .els_p   (FRF_ELS)
   )
   u_frf
   (
      .clk       (clk),
      .w_v_i     (frf_w_v),
      .w_addr_i  (wb1.frd_addr),
      .w_data_i  (wb1.frf_data),
      .r0_addr_i (id.f_instruction.rs1),
      .r0_data_o (frf_rs1_data),
      .r1_addr_i (id.f_instruction.rs2),
      .r1_data_o (frf_rs2_data)
   );

   // FMV.W.X takes rs1 from the integer side
   assign frs1_to_exe = id.f_decode.op_reads_rf1 ? rf_rs1_i : frf_rs1_data;

   // ID to EXE, rs2 always comes from the FRF
   always_ff @(posedge clk)
   begin
      if (reset || flush_now)
         exe <= '0;
      else if (advance)
         exe <= '{f_decode: id.f_decode, frd_addr: id.f_instruction.rd,
                  frs1_val: frs1_to_exe, frs2_val: frf_rs2_data};
   end

   fiu u_fiu
   (
      .frs1_i   (exe.frs1_val),
      .frs2_i   (exe.frs2_val),
      .op_i     (exe.f_decode.fiu_op),
      .result_o (fiu_result)
   );

   // EXE to MEM, flush leaves older stages alone
   always_ff @(posedge clk)
   begin
      if (reset)
         mem <= '0;
      else if (advance)
         mem <= '{op_writes_frf: exe.f_decode.op_writes_frf,
                  is_load_op: exe.f_decode.is_load_op,
                  frd_addr: exe.frd_addr, fiu_result: fiu_result};
   end

   // Loads pick up memory data here
   assign frf_data = mem.is_load_op ? flw_data_i : mem.fiu_result;

   // MEM to WB, then WB to WB1
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb  <= '0;
         wb1 <= '0;
      end
      else if (advance)
      begin
         wb  <= '{op_writes_frf: mem.op_writes_frf, frd_addr: mem.frd_addr,
                  frf_data: frf_data};
         wb1 <= wb;
      end
   end

   // Outputs to the integer core, all from EXE
   assign exe_int_result_o = fiu_result;
   assign exe_frs2_o       = exe.frs2_val;
   assign exe_store_op_o   = exe.f_decode.is_store_op;
   assign exe_writes_rf_o  = exe.f_decode.op_writes_rf;

endmodule

/* dv/fpi_sva.sv */
`timescale 1ns/1ps

module fpi_sva
(
   input logic               clk,
   input logic               reset,
   input logic               stall_i,
   input logic               flush_i,
   input fpi_isa_pkg::word_t int_result_i,
   input fpi_isa_pkg::word_t frs2_i,
   input logic               store_op_i,
   input logic               writes_rf_i
);

   // Failures seen so far, read by the testbench at the end
   int unsigned fail_count = 0;

   // Synchronous reset clears the EXE flags
   a_reset_flags: assert property (@(posedge clk) reset |=> (!store_op_i && !writes_rf_i))
      else
      begin
         fail_count++;
         $error("EXE flags still set in the cycle after reset");
      end

   // A stalled edge leaves every EXE output alone
   a_stall_hold: assert property (@(posedge clk) disable iff (reset)
      stall_i |=> ($stable(int_result_i) && $stable(frs2_i)
                   && $stable(store_op_i) && $stable(writes_rf_i)))
      else
      begin
         fail_count++;
         $error("EXE outputs changed across a stalled edge");
      end

   // Flush empties EXE, so no store can be flagged next cycle
   a_flush_store: assert property (@(posedge clk) disable iff (reset)
      (flush_i && !stall_i) |=> !store_op_i)
      else
      begin
         fail_count++;
         $error("Store flagged in EXE right after a flush");
      end

endmodule

bind fpi fpi_sva u_sva
(
   .clk          (clk),
   .reset        (reset),
   .stall_i      (alu_stall_i),
   .flush_i      (alu_flush_i),
   .int_result_i (exe_int_result_o),
   .frs2_i       (exe_frs2_o),
   .store_op_i   (exe_store_op_o),
   .writes_rf_i  (exe_writes_rf_o)
);

/* dv/fpi_tb.sv */
`timescale 1ns/1ps

module fpi_tb;

   import fpi_isa_pkg::*;

   // Instruction kinds the generator can draw
   typedef enum int {
      K_NOP, K_FLW, K_FSW, K_MVWX, K_MVXW, K_SGNJ, K_SGNJN,
      K_SGNJX, K_MIN, K_MAX, K_FEQ, K_FLT, K_FLE
   } kind_e;

   localparam int NUM_RANDOM   = 800;
   localparam int ACCEPT_LIMIT = 64;

   logic     clk;
   logic     reset;
   f_instr_s f_instruction;
   logic     alu_stall;
   logic     alu_flush;
   word_t    rf_rs1;
   word_t    flw_data;
   word_t    exe_int_result;
   word_t    exe_frs2;
   logic     exe_store_op;
   logic     exe_writes_rf;

   // Model state, stage index 0 is ID and 4 is WB1
   integer   seed;
   word_t    mfrf [32];
   kind_e    st_k [5];
   f_instr_s st_i [5];
   word_t    st_ext [5];
   word_t    st_res [5];
   word_t    st_s2 [5];
   int       last_wr [32];
   int       slot;
   // What was driven for the coming edge
   kind_e    drv_k;
   f_instr_s drv_i;
   word_t    drv_ext;
   logic     drv_stall;
   logic     drv_flush;
   logic     stall_en;
   logic     flush_en;
   logic     timed_out;
   int       err_int;
   int       err_store;
   int       err_flags;
   int       total;

   fpi u_dut
   (
      .clk              (clk),
      .reset            (reset),
      .f_instruction_i  (f_instruction),
      .alu_stall_i      (alu_stall),
      .alu_flush_i      (alu_flush),
      .rf_rs1_i         (rf_rs1),
      .flw_data_i       (flw_data),
      .exe_int_result_o (exe_int_result),
      .exe_frs2_o       (exe_frs2),
      .exe_store_op_o   (exe_store_op),
      .exe_writes_rf_o  (exe_writes_rf)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic writes_frf(input kind_e k);
      return k inside {K_FLW, K_MVWX, K_SGNJ, K_SGNJN, K_SGNJX, K_MIN, K_MAX};
   endfunction

   function automatic logic writes_rf(input kind_e k);
      return k inside {K_MVXW, K_FEQ, K_FLT, K_FLE};
   endfunction

   // Kinds that read an FRF source through rs1 or rs2
   function automatic logic reads_fs1(input kind_e k);
      return k inside {K_MVXW, K_SGNJ, K_SGNJN, K_SGNJX, K_MIN, K_MAX, K_FEQ, K_FLT, K_FLE};
   endfunction

   function automatic logic reads_fs2(input kind_e k);
      return k inside {K_FSW, K_SGNJ, K_SGNJN, K_SGNJX, K_MIN, K_MAX, K_FEQ, K_FLT, K_FLE};
   endfunction

   // Build the instruction word from the F-extension encodings
   function automatic f_instr_s encode(input kind_e k, input reg_addr_t rd,
                                       input reg_addr_t rs1, input reg_addr_t rs2);
      f_instr_s w;
      w = '0;
      w.rd  = rd;
      w.rs1 = rs1;
      w.rs2 = rs2;
      w.opcode = (k == K_FLW) ? OPC_LOAD_FP : (k == K_FSW) ? OPC_STORE_FP : OPC_OP_FP;
      case (k)
         K_MVWX:                   w.funct7 = F7_MV_W_X;
         K_MVXW:                   w.funct7 = F7_MV_X_W;
         K_SGNJ, K_SGNJN, K_SGNJX: w.funct7 = F7_SGNJ;
         K_MIN, K_MAX:             w.funct7 = F7_MINMAX;
         K_FEQ, K_FLT, K_FLE:      w.funct7 = F7_CMP;
         default:                  w.funct7 = 7'd0;
      endcase
      case (k)
         K_FLW, K_FSW: w.funct3 = F3_WORD;
         K_SGNJ:       w.funct3 = F3_SGNJ;
         K_SGNJN:      w.funct3 = F3_SGNJN;
         K_SGNJX:      w.funct3 = F3_SGNJX;
         K_MIN:        w.funct3 = F3_MIN;
         K_MAX:        w.funct3 = F3_MAX;
         K_FEQ:        w.funct3 = F3_FEQ;
         K_FLT:        w.funct3 = F3_FLT;
         K_FLE:        w.funct3 = F3_FLE;
         default:      w.funct3 = F3_MV;
      endcase
      // All-zero word has no valid opcode and decodes to a NOP
      if (k == K_NOP)
         w = '0;
      return w;
   endfunction

   // Reference float results from the operation rules
   function automatic word_t model_fiu(input kind_e k, input word_t a, input word_t b);
      logic  an;
      logic  bn;
      logic  zz;
      logic  lt;
      word_t ka;
      word_t kb;
      an = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
      bn = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
      zz = ((a | b) & 32'h7FFF_FFFF) == 32'd0;
      // Unsigned keys that sort like the floats, -0 just below +0
      ka = a[31] ? ~a : (a | 32'h8000_0000);
      kb = b[31] ? ~b : (b | 32'h8000_0000);
      lt = ka < kb;
      case (k)
         K_SGNJ:         return {b[31], a[30:0]};
         K_SGNJN:        return {~b[31], a[30:0]};
         K_SGNJX:        return {a[31] ^ b[31], a[30:0]};
         K_MIN:          return (an && bn) ? 32'h7FC0_0000 : an ? b : bn ? a : lt ? a : b;
         K_MAX:          return (an && bn) ? 32'h7FC0_0000 : an ? b : bn ? a : lt ? b : a;
         K_FEQ:          return {31'd0, !(an || bn) && ((a == b) || zz)};
         K_FLT:          return {31'd0, !(an || bn) && lt && !zz};
         K_FLE:          return {31'd0, !(an || bn) && (lt || (a == b) || zz)};
         K_MVXW, K_MVWX: return a;
         default:        return 32'd0;
      endcase
   endfunction

   // Operands biased toward NaNs, zeros, infinities and equal values
   function automatic word_t rand_fp();
      logic [31:0] r;
      r = $random(seed);
      case (r[3:0])
         4'd0:    return 32'h7FC0_0000;
         4'd1:    return {r[31], 8'hFF, 1'b0, r[22:1] | 22'd1};
         4'd2:    return 32'h0000_0000;
         4'd3:    return 32'h8000_0000;
         4'd4:    return 32'h7F80_0000;
         4'd5:    return 32'hFF80_0000;
         4'd6:    return 32'h3F80_0000;
         4'd7:    return 32'hBF80_0000;
         default: return r;
      endcase
   endfunction

   task automatic check_int_result(input word_t exp);
      if (exe_int_result !== exp)
      begin
         err_int++;
         $display("[ERROR] exe_int_result_o = %h, expected %h", exe_int_result, exp);
      end
   endtask

   task automatic check_store_data(input word_t exp);
      if (exe_frs2 !== exp)
      begin
         err_store++;
         $display("[ERROR] exe_frs2_o = %h, expected %h", exe_frs2, exp);
      end
   endtask

   task automatic check_flags(input logic exp_store, input logic exp_wrf);
      if (exe_store_op !== exp_store)
      begin
         err_flags++;
         $display("[ERROR] exe_store_op_o is %h but the model expects %h", exe_store_op, exp_store);
      end
      if (exe_writes_rf !== exp_wrf)
      begin
         err_flags++;
         $display("[ERROR] exe_writes_rf_o is %h but the model expects %h", exe_writes_rf,
                  exp_wrf);
      end
   endtask

   // Apply one rising edge to the model
   task automatic model_edge();
      word_t a;
      if (!drv_stall)
      begin
         // WB1 write lands first so the ID read sees it
         if (writes_frf(st_k[4]))
            mfrf[st_i[4].rd] = st_res[4];
         for (int s = 4; s > 1; s--)
         begin
            st_k[s]   = st_k[s-1];
            st_i[s]   = st_i[s-1];
            st_ext[s] = st_ext[s-1];
            st_res[s] = st_res[s-1];
            st_s2[s]  = st_s2[s-1];
         end
         // Load data was merged while in MEM
         if (st_k[3] == K_FLW)
            st_res[3] = st_ext[3];
         if (drv_flush)
         begin
            st_k[1]   = K_NOP;
            st_res[1] = 32'd0;
            st_k[0]   = K_NOP;
         end
         else
         begin
            a = (st_k[0] == K_MVWX) ? st_ext[0] : mfrf[st_i[0].rs1];
            st_k[1]   = st_k[0];
            st_i[1]   = st_i[0];
            st_ext[1] = st_ext[0];
            st_s2[1]  = mfrf[st_i[0].rs2];
            st_res[1] = model_fiu(st_k[0], a, st_s2[1]);
            st_k[0]   = drv_k;
            st_i[0]   = drv_i;
            st_ext[0] = drv_ext;
         end
      end
   endtask

   // One clock: update the model, check EXE, drive the next inputs
   task automatic run_cycle(input kind_e k, input f_instr_s w, input word_t ext,
                            output logic taken);
      @(negedge clk);
      model_edge();
      check_int_result(st_res[1]);
      if (st_k[1] == K_FSW)
         check_store_data(st_s2[1]);
      check_flags(st_k[1] == K_FSW, writes_rf(st_k[1]));
      drv_stall = stall_en && (($random(seed) & 7) == 0);
      drv_flush = flush_en && (($random(seed) & 15) == 0);
      drv_k     = k;
      drv_i     = w;
      drv_ext   = ext;
      f_instruction = w;
      alu_stall     = drv_stall;
      alu_flush     = drv_flush;
      // Integer rs1 for the op in ID, load data for the op in MEM, junk otherwise
      rf_rs1   = (st_k[0] == K_MVWX) ? st_ext[0] : $random(seed);
      flw_data = (st_k[2] == K_FLW) ? st_ext[2] : $random(seed);
      taken = !drv_stall;
   endtask

   // Present a word until an unstalled edge takes it
   task automatic issue(input kind_e k, input f_instr_s w, input word_t ext);
      logic taken;
      int   tries;
      taken = 1'b0;
      tries = 0;
      while (!timed_out && !taken && tries < ACCEPT_LIMIT)
      begin
         run_cycle(k, w, ext, taken);
         tries++;
      end
      if (!timed_out && !taken)
      begin
         timed_out = 1'b1;
         $display("Timeout: instruction %h was not accepted within %0d cycles", w, tries);
      end
      slot++;
   endtask

   // Pad with NOPs until the sources are 4 slots past their writers
   task automatic issue_spaced(input kind_e k, input reg_addr_t rd, input reg_addr_t rs1,
                               input reg_addr_t rs2, input word_t ext);
      int guard;
      guard = 0;
      while (!timed_out && guard < 8
             && ((reads_fs1(k) && (slot - last_wr[rs1] < 4))
                 || (reads_fs2(k) && (slot - last_wr[rs2] < 4))))
      begin
         issue(K_NOP, '0, '0);
         guard++;
      end
      if (writes_frf(k))
         last_wr[rd] = slot;
      issue(k, encode(k, rd, rs1, rs2), ext);
   endtask

   initial
   begin
      logic [31:0] r;
      seed          = 32'h2483_01f4;
      reset         = 1'b1;
      f_instruction = '0;
      alu_stall     = 1'b0;
      alu_flush     = 1'b0;
      rf_rs1        = '0;
      flw_data      = '0;
      for (int s = 0; s < 5; s++)
      begin
         st_k[s]   = K_NOP;
         st_i[s]   = '0;
         st_ext[s] = '0;
         st_res[s] = '0;
         st_s2[s]  = '0;
      end
      for (int n = 0; n < 32; n++)
         last_wr[n] = -100;
      drv_k     = K_NOP;
      drv_i     = '0;
      drv_ext   = '0;
      drv_stall = 1'b0;
      drv_flush = 1'b0;
      stall_en  = 1'b0;
      flush_en  = 1'b0;
      timed_out = 1'b0;
      slot      = 0;
      err_int   = 0;
      err_store = 0;
      err_flags = 0;
      repeat (16) @(negedge clk);
      reset    = 1'b0;
      stall_en = 1'b1;
      // Fill every FRF entry from the integer side
      for (int n = 0; n < 32; n++)
         issue_spaced(K_MVWX, reg_addr_t'(n), 5'd0, 5'd0, rand_fp());
      // Let the last fill leave ID before flushes start
      issue(K_NOP, '0, '0);
      issue(K_NOP, '0, '0);
      flush_en = 1'b1;
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         r = $random(seed);
         issue_spaced(kind_e'(int'(r[3:0]) % 13), r[8:4], r[13:9], r[18:14], rand_fp());
      end
      // Read back the whole FRF without flushes
      flush_en = 1'b0;
      for (int n = 0; n < 32; n++)
         issue_spaced(K_MVXW, 5'd0, reg_addr_t'(n), 5'd0, 32'd0);
      repeat (8) issue(K_NOP, '0, '0);
      total = err_int + err_store + err_flags + int'(u_dut.u_sva.fail_count)
              + (timed_out ? 1 : 0);
      $display("Errors: int_result %0d, store_data %0d, flags %0d, assertions %0d, timeout %0d",
               err_int, err_store, err_flags, u_dut.u_sva.fail_count, timed_out);
      if (total == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* fpi.f */
verilog/fpi_isa_pkg.sv
verilog/fpi_pipe_pkg.sv
verilog/float_decode.sv
verilog/fiu.sv
verilog/frf_2r1w.sv
verilog/fpi.sv
dv/fpi_sva.sv
dv/fpi_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fpi testbench with Verilator, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fpi_tb \
   -f fpi.f -Mdir obj_dir -o fpi_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/fpi_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1
